// File: hw/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// ============================================================
// datapath sizes for the decode stage
// ============================================================

// register and operand width
`define DATA_W      32

// register index width, 32 registers
`define REG_ADDR_W  5
`define NUM_REGS    32

`endif

// File: hw/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    // ============================================================
    // encodings
    // ============================================================

    // base opcodes of the rv32i groups handled here
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,  // reset value
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_PASS_B = 5'd10  // lui, result is operand 2
    } alu_op_e;

    // memory access kind
    // [3] store, [2:1] size (01 byte, 10 half, 11 word), [0] unsigned load
    typedef enum logic [3:0] {
        DMEM_NONE = 4'b0000,
        DMEM_LB   = 4'b0010,
        DMEM_LBU  = 4'b0011,
        DMEM_LH   = 4'b0100,
        DMEM_LHU  = 4'b0101,
        DMEM_LW   = 4'b0110,
        DMEM_SB   = 4'b1010,
        DMEM_SH   = 4'b1100,
        DMEM_SW   = 4'b1110
    } dmem_type_e;

    typedef enum logic [1:0] {
        WB_ALU      = 2'd0,
        WB_MEM      = 2'd1,
        WB_PC_PLUS4 = 2'd2  // link value for jal, jalr
    } wb_src_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_type_e;

    typedef enum logic {OP1_REG = 1'b0, OP1_PC = 1'b1} op1_sel_e;
    typedef enum logic {OP2_REG = 1'b0, OP2_IMM = 1'b1} op2_sel_e;

    // ============================================================
    // bundles
    // ============================================================

    // decoder outputs
    typedef struct packed {
        alu_op_e    alu_op;
        op1_sel_e   op1_sel;
        op2_sel_e   op2_sel;
        imm_type_e  imm_type;
        logic       beq;        // equality compare in execute
        logic       blt;        // less-than compare in execute
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        dmem_type_e dmem_type;
        wb_src_e    wb_src;
        logic       rd_we;
        logic       illegal;
    } ctrl_t;

    // id to execute pipeline register
    typedef struct packed {
        alu_op_e                alu_op;
        logic [`DATA_W-1:0]     op1;
        logic [`DATA_W-1:0]     op2;
        logic                   beq;
        logic                   blt;
        dmem_type_e             dmem_type;
        logic [`DATA_W-1:0]     ext_imm;
        logic [`DATA_W-1:0]     pc_plus4;
        logic                   rd_we;
        logic [`REG_ADDR_W-1:0] rd_idx;
        wb_src_e                wb_src;
        logic                   illegal;
    } id_ex_t;

    // write-back request into the register file
    typedef struct packed {
        logic                   we;
        logic [`REG_ADDR_W-1:0] rd_idx;
        logic [`DATA_W-1:0]     data;
    } wb_req_t;

    // redirect back to fetch
    typedef struct packed {
        logic               taken;
        logic [`DATA_W-1:0] target;
    } redirect_t;

endpackage

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage import decode_pkg::*; (
    input  logic               clk,
    input  logic               resetn,      // also flushes id/ex
    input  logic               enable_i,    // low = stall
    input  logic [31:0]        instr_i,
    input  logic [`DATA_W-1:0] pc_i,
    input  logic [`DATA_W-1:0] pc_plus4_i,
    input  wb_req_t            wb_i,
    input  logic               rs1_dep_i,
    output id_ex_t             id_ex_o,
    output redirect_t          redirect_o
);

    // ============================================================
    // decode, immediate, register read
    // ============================================================
    ctrl_t                  ctrl;
    logic [`DATA_W-1:0]     imm;
    logic [`REG_ADDR_W-1:0] rs1_idx, rs2_idx, rd_idx;
    logic [`DATA_W-1:0]     rs1_data, rs2_data;
    id_ex_t                 id_ex_d;

    assign rd_idx  = instr_i[11:7];
    assign rs1_idx = instr_i[19:15];
    // jumps read x0 as the second alu operand
    assign rs2_idx = (ctrl.is_jal || ctrl.is_jalr) ? '0 : instr_i[24:20];

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    imm_extender u_imm (
        .instr_i    (instr_i),
        .imm_type_i (ctrl.imm_type),
        .imm_o      (imm)
    );

    register_file u_rf (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_addr_i (rs1_idx),
        .rs2_addr_i (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb_i)
    );

    // redirect is combinational, straight to fetch
    static_branch_predictor u_bp (
        .is_branch_i (ctrl.is_branch),
        .is_jal_i    (ctrl.is_jal),
        .is_jalr_i   (ctrl.is_jalr),
        .pc_i        (pc_i),
        .rs1_data_i  (rs1_data),
        .imm_i       (imm),
        .rs1_dep_i   (rs1_dep_i),
        .redirect_o  (redirect_o)
    );

    // ============================================================
    // operand select and id/ex register
    // ============================================================
    always_comb begin
        id_ex_d           = '0;
        id_ex_d.alu_op    = ctrl.alu_op;
        // pc side: link value for jumps, plain pc for auipc
        if (ctrl.op1_sel == OP1_PC)
            id_ex_d.op1 = (ctrl.is_jal || ctrl.is_jalr) ? pc_plus4_i : pc_i;
        else
            id_ex_d.op1 = rs1_data;
        id_ex_d.op2       = (ctrl.op2_sel == OP2_IMM) ? imm : rs2_data;
        id_ex_d.beq       = ctrl.beq;
        id_ex_d.blt       = ctrl.blt;
        id_ex_d.dmem_type = ctrl.dmem_type;
        id_ex_d.ext_imm   = imm;
        id_ex_d.pc_plus4  = pc_plus4_i;
        id_ex_d.rd_we     = ctrl.rd_we;
        id_ex_d.rd_idx    = rd_idx;
        id_ex_d.wb_src    = ctrl.wb_src;
        id_ex_d.illegal   = ctrl.illegal;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_ex_o        <= '0;       // bubble
            id_ex_o.alu_op <= ALU_ADD;
        end else if (enable_i) begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

// File: hw/imm_extender.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module imm_extender import decode_pkg::*; (
    input  logic [31:0]        instr_i,
    input  imm_type_e          imm_type_i,
    output logic [`DATA_W-1:0] imm_o
);

    logic sign; // bit 31 is the sign for every format

    assign sign = instr_i[31];

    always_comb begin
        case (imm_type_i)
            IMM_I: imm_o = {{20{sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            // branch offset, bit 0 implied zero
            IMM_B: imm_o = {{19{sign}}, sign, instr_i[7], instr_i[30:25],
                            instr_i[11:8], 1'b0};
            IMM_U: imm_o = {instr_i[31:12], 12'b0};  // upper 20 bits
            IMM_J: imm_o = {{11{sign}}, sign, instr_i[19:12], instr_i[20],
                            instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// File: hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import decode_pkg::*; (
    input  logic [31:0] instr_i,
    output ctrl_t       ctrl_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // funct3 to alu op with alt picking sub or sra
    function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ============================================================
    // main decode
    // ============================================================
    always_comb begin
        ctrl_o          = '0;
        ctrl_o.alu_op   = ALU_ADD;
        ctrl_o.op1_sel  = OP1_REG;
        ctrl_o.op2_sel  = OP2_REG;
        ctrl_o.imm_type = IMM_I;
        ctrl_o.dmem_type = DMEM_NONE;
        ctrl_o.wb_src   = WB_ALU;

        case (opcode)
            OPC_LUI: begin
                ctrl_o.alu_op   = ALU_PASS_B;
                ctrl_o.op2_sel  = OP2_IMM;
                ctrl_o.imm_type = IMM_U;
                ctrl_o.rd_we    = 1'b1;
            end
            OPC_AUIPC: begin // pc + upper imm
                ctrl_o.op1_sel  = OP1_PC;
                ctrl_o.op2_sel  = OP2_IMM;
                ctrl_o.imm_type = IMM_U;
                ctrl_o.rd_we    = 1'b1;
            end
            OPC_JAL: begin // link = pc+4 + x0
                ctrl_o.is_jal   = 1'b1;
                ctrl_o.op1_sel  = OP1_PC;
                ctrl_o.imm_type = IMM_J;
                ctrl_o.wb_src   = WB_PC_PLUS4;
                ctrl_o.rd_we    = 1'b1;
            end
            OPC_JALR: begin
                ctrl_o.is_jalr  = 1'b1;
                ctrl_o.op1_sel  = OP1_PC;
                ctrl_o.wb_src   = WB_PC_PLUS4;
                ctrl_o.rd_we    = 1'b1;
                ctrl_o.illegal  = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                ctrl_o.is_branch = 1'b1;
                ctrl_o.imm_type  = IMM_B;
                case (funct3)
                    3'b000, 3'b001: begin // beq, bne
                        ctrl_o.alu_op = ALU_SUB;
                        ctrl_o.beq    = 1'b1;
                    end
                    3'b100, 3'b101: begin // blt, bge
                        ctrl_o.alu_op = ALU_SLT;
                        ctrl_o.blt    = 1'b1;
                    end
                    3'b110, 3'b111: begin // unsigned forms
                        ctrl_o.alu_op = ALU_SLTU;
                        ctrl_o.blt    = 1'b1;
                    end
                    default: ctrl_o.illegal = 1'b1;
                endcase
            end
            OPC_LOAD: begin // address = rs1 + imm
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.wb_src  = WB_MEM;
                ctrl_o.rd_we   = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = DMEM_LB;
                    3'b001:  ctrl_o.dmem_type = DMEM_LH;
                    3'b010:  ctrl_o.dmem_type = DMEM_LW;
                    3'b100:  ctrl_o.dmem_type = DMEM_LBU;
                    3'b101:  ctrl_o.dmem_type = DMEM_LHU;
                    default: ctrl_o.illegal   = 1'b1;
                endcase
            end
            OPC_STORE: begin
                ctrl_o.op2_sel  = OP2_IMM;
                ctrl_o.imm_type = IMM_S;
                case (funct3)
                    3'b000:  ctrl_o.dmem_type = DMEM_SB;
                    3'b001:  ctrl_o.dmem_type = DMEM_SH;
                    3'b010:  ctrl_o.dmem_type = DMEM_SW;
                    default: ctrl_o.illegal   = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.rd_we   = 1'b1;
                ctrl_o.alu_op  = f3_to_alu(funct3, (funct3 == 3'b101) && funct7[5]);
                // shifts carry funct7 in the imm field
                if (funct3 == 3'b001)
                    ctrl_o.illegal = (funct7 != 7'b0000000);
                else if (funct3 == 3'b101)
                    ctrl_o.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
            OPC_OP: begin
                ctrl_o.rd_we  = 1'b1;
                ctrl_o.alu_op = f3_to_alu(funct3, funct7[5]);
                if (funct7 == 7'b0100000)
                    ctrl_o.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                else
                    ctrl_o.illegal = (funct7 != 7'b0000000);
            end
            // fence, csr, system, unknown, and every 16-bit word
            // since all opcodes above end in 11
            default: ctrl_o.illegal = 1'b1;
        endcase

        // no side effects for an illegal word
        if (ctrl_o.illegal) begin
            ctrl_o.rd_we     = 1'b0;
            ctrl_o.dmem_type = DMEM_NONE;
            ctrl_o.is_branch = 1'b0;
            ctrl_o.is_jal    = 1'b0;
            ctrl_o.is_jalr   = 1'b0;
        end
    end

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module register_file import decode_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`DATA_W-1:0]     rs1_data_o,
    output logic [`DATA_W-1:0]     rs2_data_o,
    input  wb_req_t                wb_i
);

    // x1..x31, x0 has no storage
    logic [`DATA_W-1:0] regs [1:`NUM_REGS-1];

    logic wr_ok;

    assign wr_ok = wb_i.we && (wb_i.rd_idx != '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_ok) begin
            regs[wb_i.rd_idx] <= wb_i.data;
        end
    end

    // read with bypass of a write in the same cycle
    function automatic logic [`DATA_W-1:0] rd_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;                          // x0
        else if (wr_ok && (wb_i.rd_idx == addr))
            return wb_i.data;                   // forward
        else
            return regs[addr];
    endfunction

    assign rs1_data_o = rd_port(rs1_addr_i);
    assign rs2_data_o = rd_port(rs2_addr_i);

endmodule

// File: hw/static_branch_predictor.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module static_branch_predictor import decode_pkg::*; (
    input  logic               is_branch_i,
    input  logic               is_jal_i,
    input  logic               is_jalr_i,
    input  logic [`DATA_W-1:0] pc_i,
    input  logic [`DATA_W-1:0] rs1_data_i,
    input  logic [`DATA_W-1:0] imm_i,
    input  logic               rs1_dep_i,   // rs1 still in flight
    output redirect_t          redirect_o
);

    logic [`DATA_W-1:0] pc_rel;    // jal and b-type
    logic [`DATA_W-1:0] reg_rel;   // jalr

    assign pc_rel  = pc_i + imm_i;
    assign reg_rel = rs1_data_i + imm_i;

    always_comb begin
        redirect_o = '0;
        if (is_jal_i) begin
            redirect_o.taken  = 1'b1;
            redirect_o.target = pc_rel;
        end else if (is_jalr_i) begin
            // only with a settled rs1
            if (!rs1_dep_i) begin
                redirect_o.taken  = 1'b1;
                redirect_o.target = {reg_rel[`DATA_W-1:1], 1'b0};
            end
        end else if (is_branch_i) begin
            redirect_o.taken  = imm_i[`DATA_W-1];  // backward taken, forward not
            redirect_o.target = pc_rel;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module decode_stage_tb \
    -f sources.f -o decode_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/decode_sim > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "test failed"; exit 1; } || echo "test passed"

// File: sources.f
+incdir+hw
hw/decode_pkg.sv
hw/instr_decoder.sv
hw/imm_extender.sv
hw/register_file.sv
hw/static_branch_predictor.sv
hw/decode_stage.sv
tests/decode_stage_props.sv
tests/decode_stage_tb.sv

// File: tests/decode_stage_props.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_props import decode_pkg::*; (
    input logic                   clk,
    input logic                   resetn,
    input logic                   enable_i,
    input id_ex_t                 id_ex_o,
    input logic [`REG_ADDR_W-1:0] rs1_idx,
    input logic [`REG_ADDR_W-1:0] rs2_idx,
    input logic [`DATA_W-1:0]     rs1_data,
    input logic [`DATA_W-1:0]     rs2_data
);

    // flush leaves a bubble behind
    a_flush_bubble: assert property (@(posedge clk)
        !resetn |=> (!id_ex_o.rd_we && !id_ex_o.illegal))
        else $error("id_ex not cleared after flush");

    // stall holds the whole register
    a_stall_hold: assert property (@(posedge clk)
        (resetn && !enable_i) |=> $stable(id_ex_o))
        else $error("id_ex changed during stall");

    // x0 on both read ports
    a_x0_rs1: assert property (@(posedge clk) (rs1_idx == '0) |-> (rs1_data == '0))
        else $error("x0 nonzero on rs1 port");
    a_x0_rs2: assert property (@(posedge clk) (rs2_idx == '0) |-> (rs2_data == '0))
        else $error("x0 nonzero on rs2 port");

endmodule

// File: tests/decode_stage_tb.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_stage_tb import decode_pkg::*; ();

    typedef struct {
        string       name;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        dep;
        logic        en;
        logic        rst;      // pulse resetn low at this edge
        wb_req_t     wb;
        id_ex_t      ex;       // expected one edge later
        redirect_t   rd;       // expected in the same cycle
        logic        chk_imm;
        logic        chk_ops;
    } row_t;

    logic        clk;
    logic        resetn;
    logic        enable_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic [31:0] pc_plus4_i;
    wb_req_t     wb_i;
    logic        rs1_dep_i;
    id_ex_t      id_ex_o;
    redirect_t   redirect_o;

    row_t        rows[$];
    logic [31:0] sh [0:31];         // shadow of the register file
    logic [31:0] lcg_state = 32'd24;
    int          checks = 0;
    int          errors = 0;
    int          mark = 0;
    int          settle = 0;

    decode_stage u_dut (
        .clk        (clk),
        .resetn     (resetn),
        .enable_i   (enable_i),
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .pc_plus4_i (pc_plus4_i),
        .wb_i       (wb_i),
        .rs1_dep_i  (rs1_dep_i),
        .id_ex_o    (id_ex_o),
        .redirect_o (redirect_o)
    );

    bind decode_stage decode_stage_props u_props (.*);

    always #2 clk = ~clk;   // 4 ns period

    // ============================================================
    // helpers
    // ============================================================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // bubble-like default, only rd field and pc+4 filled in
    function automatic id_ex_t base(input logic [31:0] ins, input logic [31:0] pc);
        id_ex_t e;
        e          = '0;
        e.alu_op   = ALU_ADD;
        e.pc_plus4 = pc + 32'd4;
        e.rd_idx   = ins[11:7];
        return e;
    endfunction

    task automatic compare(input string nm, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h expected 0x%h", nm, got, exp);
        end
    endtask

    task automatic add_row(input string nm, input logic [31:0] ins, input logic [31:0] pc,
                           input logic dep, input logic en, input logic rst,
                           input wb_req_t wb, input id_ex_t ex, input redirect_t rd,
                           input logic ci, input logic co);
        row_t r;
        r.name    = nm;
        r.instr   = ins;
        r.pc      = pc;
        r.dep     = dep;
        r.en      = en;
        r.rst     = rst;
        r.wb      = wb;
        r.ex      = ex;
        r.rd      = rd;
        r.chk_imm = ci;
        r.chk_ops = co;
        rows.push_back(r);
    endtask

    task automatic check_id_ex(input row_t r);
        compare("id_ex.alu_op", 32'(id_ex_o.alu_op), 32'(r.ex.alu_op));
        compare("id_ex.beq", 32'(id_ex_o.beq), 32'(r.ex.beq));
        compare("id_ex.blt", 32'(id_ex_o.blt), 32'(r.ex.blt));
        compare("id_ex.dmem_type", 32'(id_ex_o.dmem_type), 32'(r.ex.dmem_type));
        compare("id_ex.pc_plus4", id_ex_o.pc_plus4, r.ex.pc_plus4);
        compare("id_ex.rd_we", 32'(id_ex_o.rd_we), 32'(r.ex.rd_we));
        compare("id_ex.rd_idx", 32'(id_ex_o.rd_idx), 32'(r.ex.rd_idx));
        compare("id_ex.wb_src", 32'(id_ex_o.wb_src), 32'(r.ex.wb_src));
        compare("id_ex.illegal", 32'(id_ex_o.illegal), 32'(r.ex.illegal));
        if (r.chk_ops) begin
            compare("id_ex.op1", id_ex_o.op1, r.ex.op1);
            compare("id_ex.op2", id_ex_o.op2, r.ex.op2);
        end
        if (r.chk_imm)
            compare("id_ex.ext_imm", id_ex_o.ext_imm, r.ex.ext_imm);
    endtask

    task automatic check_redirect(input row_t r);
        compare("redirect.taken", 32'(redirect_o.taken), 32'(r.rd.taken));
        compare("redirect.target", redirect_o.target, r.rd.target);
    endtask

    task automatic preload_regs();
        wb_req_t w;
        for (int i = 1; i <= 7; i++) begin
            @(posedge clk);
            sh[i]    = lcg_next();
            w.we     = 1'b1;
            w.rd_idx = 5'(i);
            w.data   = sh[i];
            wb_i    <= w;
        end
        @(posedge clk);
        wb_i <= '0;
    endtask

    // ============================================================
    // stimulus table, expected values from shadow registers
    // ============================================================
    task automatic build_table();
        id_ex_t      e;
        redirect_t   rd;
        wb_req_t     w;
        logic [31:0] ins;
        w  = '0;
        rd = '0;
        // r-type
        ins = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd8);
        e = base(ins, 32'h100);
        e.op1 = sh[1];
        e.op2 = sh[2];
        e.rd_we = 1'b1;
        add_row("add", ins, 32'h100, 0, 1, 0, w, e, rd, 0, 1);
        ins = enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd9);
        e = base(ins, 32'h104);
        e.alu_op = ALU_SUB;
        e.op1 = sh[3];
        e.op2 = sh[4];
        e.rd_we = 1'b1;
        add_row("sub", ins, 32'h104, 0, 1, 0, w, e, rd, 0, 1);
        ins = enc_r(7'h00, 5'd6, 5'd5, 3'd2, 5'd10);
        e = base(ins, 32'h108);
        e.alu_op = ALU_SLT;
        e.op1 = sh[5];
        e.op2 = sh[6];
        e.rd_we = 1'b1;
        add_row("slt", ins, 32'h108, 0, 1, 0, w, e, rd, 0, 1);
        ins = enc_r(7'h00, 5'd1, 5'd7, 3'd7, 5'd11);
        e = base(ins, 32'h10c);
        e.alu_op = ALU_AND;
        e.op1 = sh[7];
        e.op2 = sh[1];
        e.rd_we = 1'b1;
        add_row("and", ins, 32'h10c, 0, 1, 0, w, e, rd, 0, 1);
        // same-cycle write to rs1 is forwarded
        w = '{we: 1'b1, rd_idx: 5'd3, data: 32'hcafe0003};
        ins = enc_r(7'h00, 5'd2, 5'd3, 3'd0, 5'd12);
        e = base(ins, 32'h110);
        e.op1 = 32'hcafe0003;
        e.op2 = sh[2];
        e.rd_we = 1'b1;
        add_row("add fwd", ins, 32'h110, 0, 1, 0, w, e, rd, 0, 1);
        sh[3] = 32'hcafe0003;
        // x0 ignores writes
        w = '{we: 1'b1, rd_idx: 5'd0, data: 32'h0000dead};
        ins = enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd13);
        e = base(ins, 32'h114);
        e.op1 = 32'h0;
        e.op2 = sh[2];
        e.rd_we = 1'b1;
        add_row("add x0", ins, 32'h114, 0, 1, 0, w, e, rd, 0, 1);
        w = '0;
        // immediates
        ins = enc_i(12'hffb, 5'd1, 3'd0, 5'd14, 7'h13);
        e = base(ins, 32'h118);
        e.op1 = sh[1];
        e.op2 = 32'hfffffffb;
        e.ext_imm = 32'hfffffffb;
        e.rd_we = 1'b1;
        add_row("addi", ins, 32'h118, 0, 1, 0, w, e, rd, 1, 1);
        ins = enc_i(12'd100, 5'd2, 3'd2, 5'd15, 7'h03);
        e = base(ins, 32'h11c);
        e.op1 = sh[2];
        e.op2 = 32'd100;
        e.ext_imm = 32'd100;
        e.dmem_type = DMEM_LW;
        e.wb_src = WB_MEM;
        e.rd_we = 1'b1;
        add_row("lw", ins, 32'h11c, 0, 1, 0, w, e, rd, 1, 1);
        ins = enc_i(12'hfff, 5'd4, 3'd4, 5'd16, 7'h03);
        e = base(ins, 32'h120);
        e.op1 = sh[4];
        e.op2 = 32'hffffffff;
        e.ext_imm = 32'hffffffff;
        e.dmem_type = DMEM_LBU;
        e.wb_src = WB_MEM;
        e.rd_we = 1'b1;
        add_row("lbu", ins, 32'h120, 0, 1, 0, w, e, rd, 1, 1);
        ins = enc_s(12'hff8, 5'd5, 5'd6, 3'd2);
        e = base(ins, 32'h124);
        e.op1 = sh[6];
        e.op2 = 32'hfffffff8;
        e.ext_imm = 32'hfffffff8;
        e.dmem_type = DMEM_SW;
        add_row("sw", ins, 32'h124, 0, 1, 0, w, e, rd, 1, 1);
        ins = {20'h12345, 5'd17, 7'b0110111};
        e = base(ins, 32'h128);
        e.alu_op = ALU_PASS_B;
        e.op1 = sh[ins[19:15]];
        e.op2 = 32'h12345000;
        e.ext_imm = 32'h12345000;
        e.rd_we = 1'b1;
        add_row("lui", ins, 32'h128, 0, 1, 0, w, e, rd, 1, 1);
        ins = {20'h00001, 5'd18, 7'b0010111};
        e = base(ins, 32'h140);
        e.op1 = 32'h140;
        e.op2 = 32'h1000;
        e.ext_imm = 32'h1000;
        e.rd_we = 1'b1;
        add_row("auipc", ins, 32'h140, 0, 1, 0, w, e, rd, 1, 1);
        // jumps, link value is pc+4 plus x0
        ins = enc_j(21'h1ffff0, 5'd1);
        e = base(ins, 32'h200);
        e.op1 = 32'h204;
        e.ext_imm = 32'hfffffff0;
        e.wb_src = WB_PC_PLUS4;
        e.rd_we = 1'b1;
        rd = '{taken: 1'b1, target: 32'h1f0};
        add_row("jal", ins, 32'h200, 0, 1, 0, w, e, rd, 1, 1);
        ins = enc_i(12'd6, 5'd2, 3'd0, 5'd1, 7'h67);
        e = base(ins, 32'h220);
        e.op1 = 32'h224;
        e.ext_imm = 32'd6;
        e.wb_src = WB_PC_PLUS4;
        e.rd_we = 1'b1;
        rd = '{taken: 1'b1, target: (sh[2] + 32'd6) & ~32'd1};
        add_row("jalr", ins, 32'h220, 0, 1, 0, w, e, rd, 1, 1);
        rd = '0;
        add_row("jalr dep", ins, 32'h220, 1, 1, 0, w, e, rd, 1, 1);
        // branches, backward taken
        ins = enc_b(13'h1ff8, 5'd1, 5'd2, 3'd0);
        e = base(ins, 32'h300);
        e.alu_op = ALU_SUB;
        e.beq = 1'b1;
        e.op1 = sh[1];
        e.op2 = sh[2];
        e.ext_imm = 32'hfffffff8;
        rd = '{taken: 1'b1, target: 32'h2f8};
        add_row("beq back", ins, 32'h300, 0, 1, 0, w, e, rd, 1, 1);
        ins = enc_b(13'd12, 5'd3, 5'd4, 3'd4);
        e = base(ins, 32'h310);
        e.alu_op = ALU_SLT;
        e.blt = 1'b1;
        e.op1 = sh[3];
        e.op2 = sh[4];
        e.ext_imm = 32'd12;
        rd = '{taken: 1'b0, target: 32'h31c};
        add_row("blt fwd", ins, 32'h310, 0, 1, 0, w, e, rd, 1, 1);
        rd = '0;
        // stall keeps blt, then flush clears id_ex and the registers
        ins = enc_i(12'd3, 5'd1, 3'd0, 5'd20, 7'h13);
        add_row("stall", ins, 32'h314, 0, 0, 0, w, rows[$].ex, rd, 1, 1);
        ins = enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd8);
        e = '0;
        e.alu_op = ALU_ADD;
        add_row("flush", ins, 32'h318, 0, 1, 1, w, e, rd, 1, 1);
        for (int i = 0; i < 32; i++)
            sh[i] = 32'h0;
        e = base(ins, 32'h31c);
        e.rd_we = 1'b1;
        add_row("add cleared", ins, 32'h31c, 0, 1, 0, w, e, rd, 0, 1);
        // illegal words
        e = base(32'h0000007f, 32'h320);
        e.illegal = 1'b1;
        add_row("bad opcode", 32'h0000007f, 32'h320, 0, 1, 0, w, e, rd, 0, 0);
        ins = enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd9);
        e = base(ins, 32'h324);
        e.illegal = 1'b1;
        add_row("bad funct7", ins, 32'h324, 0, 1, 0, w, e, rd, 0, 0);
        e = base(32'h00004501, 32'h328);
        e.illegal = 1'b1;
        add_row("16-bit", 32'h00004501, 32'h328, 0, 1, 0, w, e, rd, 0, 0);
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        enable_i   = 1'b0;
        instr_i    = 32'h0;
        pc_i       = 32'h0;
        pc_plus4_i = 32'h4;
        wb_i       = '0;
        rs1_dep_i  = 1'b0;
        for (int i = 0; i < 32; i++)
            sh[i] = 32'h0;
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        // bubble must be visible before the table starts
        while ((id_ex_o.rd_we !== 1'b0) && (settle < 20)) begin
            @(posedge clk);
            settle++;
        end
        if (settle >= 20) begin
            $display("timeout: id_ex never cleared after reset");
            $display("Result: FAILED");
            $finish;
        end
        preload_regs();
        build_table();
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            resetn     <= !rows[i].rst;
            enable_i   <= rows[i].en;
            instr_i    <= rows[i].instr;
            pc_i       <= rows[i].pc;
            pc_plus4_i <= rows[i].pc + 32'd4;
            rs1_dep_i  <= rows[i].dep;
            wb_i       <= rows[i].wb;
            @(negedge clk);
            if (i > 0) begin // previous row has reached id_ex
                check_id_ex(rows[i-1]);
                $display("row %0d %s: %0d errors", i - 1, rows[i-1].name, errors - mark);
                mark = errors;
            end
            check_redirect(rows[i]);
        end
        @(posedge clk);
        resetn   <= 1'b1;
        enable_i <= 1'b0;
        wb_i     <= '0;
        @(negedge clk);
        check_id_ex(rows[$]);
        $display("row %0d %s: %0d errors", rows.size() - 1, rows[$].name, errors - mark);
        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #20000;
        $display("timeout: table did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule
